// ==== files.f ====
hdl/regfile_pkg.sv
hdl/regfile_bank_ram.sv
hdl/regfile_live_table.sv
hdl/regfile_read_mux.sv
hdl/regfile_2w10r.sv
testbench/regfile_props.sv
testbench/tb_regfile_2w10r.sv

// ==== hdl/regfile_2w10r.sv ====
`timescale 1ns/1ps

// Integer register file with two write ports and ten read ports.
// Each write port owns a bank with one RAM copy per read port. The live
// table picks, byte by byte, which bank holds the newest value.

module regfile_2w10r (
  input  logic                              clka,
  input  logic                              rst,
  input  regfile_pkg::wr_port_t             wr0,
  input  regfile_pkg::wr_port_t             wr1,
  input  logic [regfile_pkg::xlen-1:0]      pc0,
  input  logic [regfile_pkg::xlen-1:0]      pc1,
  input  regfile_pkg::rd_addr_vec_t         rd_addr,
  output regfile_pkg::rd_data_vec_t         rd_data
);

  // ====================
  // Internal signals
  // ====================

  // Write ports and lane pcs as arrays so the generate loops can index them
  regfile_pkg::wr_port_t          wr      [2];
  logic [regfile_pkg::xlen-1:0]   lane_pc [2];

  // Value of each bank copy, indexed by write port then read port
  logic [regfile_pkg::xlen-1:0]   bank_data [2][regfile_pkg::nrd];

  // Live byte mask of the register each read port addresses
  logic [regfile_pkg::nrd-1:0][regfile_pkg::nbytes-1:0] live;

  assign wr[0]      = wr0;
  assign wr[1]      = wr1;
  assign lane_pc[0] = pc0;
  assign lane_pc[1] = pc1;

  // ====================
  // Banks
  // ====================

  // Copy (p, k) is written by port p and read by port k
  for (genvar p = 0; p < 2; p++) begin : g_bank
    for (genvar k = 0; k < regfile_pkg::nrd; k++) begin : g_copy
      regfile_bank_ram u_bank_ram (
        .clka    (clka),
        .wr      (wr[p]),
        .rd_addr (rd_addr[k]),
        .rd_data (bank_data[p][k])
      );
    end
  end

  // ====================
  // Live table
  // ====================

  regfile_live_table u_live_table (
    .clka    (clka),
    .rst     (rst),
    .wr0     (wr0),
    .wr1     (wr1),
    .rd_addr (rd_addr),
    .live    (live)
  );

  // ====================
  // Read ports
  // ====================

  // The last port of each lane returns all ones for register 63 and has
  // no use for the pc. The other four return the lane's pc for register 53
  for (genvar k = 0; k < regfile_pkg::nrd; k++) begin : g_rd
    localparam int lane  = k / regfile_pkg::rd_per_lane;
    localparam bit fifth = (k % regfile_pkg::rd_per_lane) == (regfile_pkg::rd_per_lane - 1);

    if (fifth) begin : g_ones
      regfile_read_mux #(
        .kind (regfile_pkg::rd_ones)
      ) u_read_mux (
        .rd_addr    (rd_addr[k]),
        .wr0        (wr0),
        .wr1        (wr1),
        .live       (live[k]),
        .bank0_data (bank_data[0][k]),
        .bank1_data (bank_data[1][k]),
        .pc         (),
        .rd_data    (rd_data[k])
      );
    end else begin : g_pc
      regfile_read_mux #(
        .kind (regfile_pkg::rd_pc)
      ) u_read_mux (
        .rd_addr    (rd_addr[k]),
        .wr0        (wr0),
        .wr1        (wr1),
        .live       (live[k]),
        .bank0_data (bank_data[0][k]),
        .bank1_data (bank_data[1][k]),
        .pc         (lane_pc[lane]),
        .rd_data    (rd_data[k])
      );
    end
  end

endmodule

// ==== hdl/regfile_bank_ram.sv ====
`timescale 1ns/1ps

// One copy of a write port's bank. Each read port has its own copy, so
// every copy sees the same writes and serves exactly one read address.

module regfile_bank_ram (
  input  logic                              clka,
  input  regfile_pkg::wr_port_t             wr,
  input  logic [regfile_pkg::reg_aw-1:0]    rd_addr,
  output logic [regfile_pkg::xlen-1:0]      rd_data
);

  // ====================
  // Storage
  // ====================

  // All registers hold zero from time 0 on
  logic [regfile_pkg::xlen-1:0] mem [regfile_pkg::nregs] = '{default: '0};

  // Byte-masked write, committed at the edge after the strobe
  always_ff @(posedge clka) begin
    if (wr.en) begin
      for (int b = 0; b < regfile_pkg::nbytes; b++) begin
        if (wr.be[b]) begin
          mem[wr.addr][b*8 +: 8] <= wr.data[b*8 +: 8];
        end
      end
    end
  end

  // ====================
  // Read
  // ====================

  // Asynchronous read, maps onto distributed RAM
  assign rd_data = mem[rd_addr];

endmodule

// ==== hdl/regfile_live_table.sv ====
`timescale 1ns/1ps

// Live-value table with one bit per byte of every register.
// A bit of 0 means bank 0 holds the newest copy of the byte, 1 means bank 1.
// Tracking bytes instead of whole registers lets partial writes from the
// two ports merge into one register.

module regfile_live_table (
  input  logic                                                   clka,
  input  logic                                                   rst,
  input  regfile_pkg::wr_port_t                                  wr0,
  input  regfile_pkg::wr_port_t                                  wr1,
  input  regfile_pkg::rd_addr_vec_t                              rd_addr,
  output logic [regfile_pkg::nrd-1:0][regfile_pkg::nbytes-1:0]   live
);

  // ====================
  // Live bits
  // ====================

  logic [regfile_pkg::nregs-1:0][regfile_pkg::nbytes-1:0] live_bits;

  // Port 1 updates come after port 0 in the loop body, so when both
  // ports write the same byte the later nonblocking assignment wins
  always_ff @(posedge clka) begin
    if (rst) begin
      live_bits <= '0;
    end else begin
      for (int b = 0; b < regfile_pkg::nbytes; b++) begin
        if (wr0.en && wr0.be[b]) begin
          live_bits[wr0.addr][b] <= 1'b0;
        end
        if (wr1.en && wr1.be[b]) begin
          live_bits[wr1.addr][b] <= 1'b1;
        end
      end
    end
  end

  // ====================
  // Lookup
  // ====================

  // One mask per read port, taken from the addressed register
  always_comb begin
    for (int k = 0; k < regfile_pkg::nrd; k++) begin
      live[k] = live_bits[rd_addr[k]];
    end
  end

endmodule

// ==== hdl/regfile_pkg.sv ====
// ====================
// Register file shared definitions
// ====================

package regfile_pkg;

  // Geometry of the integer register file
  localparam int xlen        = 64;
  localparam int nregs       = 64;
  localparam int reg_aw      = 6;
  localparam int nbytes      = 8;

  // Read ports, five per retiring lane
  localparam int nrd         = 10;
  localparam int rd_per_lane = 5;

  // Register numbers with fixed read values
  localparam logic [reg_aw-1:0] reg_zero = reg_aw'(0);
  localparam logic [reg_aw-1:0] reg_pc   = reg_aw'(53);
  localparam logic [reg_aw-1:0] reg_ones = reg_aw'(63);

  // What the special register of a read port returns.
  // The four operand ports of a lane see the pc, the fifth sees all ones
  typedef enum logic {
    rd_pc   = 1'b0,
    rd_ones = 1'b1
  } rd_kind_e;

  // ====================
  // Port bundles
  // ====================

  // One write port from a retiring lane.
  // The be bits select which byte lanes of data land in the register
  typedef struct packed {
    logic                en;
    logic [nbytes-1:0]   be;
    logic [reg_aw-1:0]   addr;
    logic [xlen-1:0]     data;
  } wr_port_t;

  // Read addresses and read data for all ten ports.
  // Ports 0 to 4 belong to lane 0, ports 5 to 9 to lane 1
  typedef logic [nrd-1:0][reg_aw-1:0] rd_addr_vec_t;
  typedef logic [nrd-1:0][xlen-1:0]   rd_data_vec_t;

endpackage

// ==== hdl/regfile_read_mux.sv ====
`timescale 1ns/1ps

// Output logic of one read port.
// Priority from highest to lowest is the special registers, then the
// same-cycle bypass from port 1, then from port 0, and last the bank
// that the live table names for each byte.

module regfile_read_mux #(
  parameter regfile_pkg::rd_kind_e kind = regfile_pkg::rd_pc
) (
  input  logic [regfile_pkg::reg_aw-1:0]    rd_addr,
  input  regfile_pkg::wr_port_t             wr0,
  input  regfile_pkg::wr_port_t             wr1,
  input  logic [regfile_pkg::nbytes-1:0]    live,
  input  logic [regfile_pkg::xlen-1:0]      bank0_data,
  input  logic [regfile_pkg::xlen-1:0]      bank1_data,
  input  logic [regfile_pkg::xlen-1:0]      pc,
  output logic [regfile_pkg::xlen-1:0]      rd_data
);

  // ====================
  // Bypass match
  // ====================

  logic [regfile_pkg::nbytes-1:0] hit0;
  logic [regfile_pkg::nbytes-1:0] hit1;
  logic [regfile_pkg::xlen-1:0]   merged;

  // Bytes that a write in this cycle targets at our address
  assign hit0 = (wr0.en && (wr0.addr == rd_addr)) ? wr0.be : '0;
  assign hit1 = (wr1.en && (wr1.addr == rd_addr)) ? wr1.be : '0;

  // ====================
  // Byte merge
  // ====================

  always_comb begin
    for (int b = 0; b < regfile_pkg::nbytes; b++) begin
      if (hit1[b]) begin
        merged[b*8 +: 8] = wr1.data[b*8 +: 8];
      end else if (hit0[b]) begin
        merged[b*8 +: 8] = wr0.data[b*8 +: 8];
      end else if (live[b]) begin
        merged[b*8 +: 8] = bank1_data[b*8 +: 8];
      end else begin
        merged[b*8 +: 8] = bank0_data[b*8 +: 8];
      end
    end
  end

  // ====================
  // Special registers
  // ====================

  // Register 53 on a fifth port and register 63 on an operand port are
  // ordinary storage
  always_comb begin
    if (rd_addr == regfile_pkg::reg_zero) begin
      rd_data = '0;
    end else if (kind == regfile_pkg::rd_pc && rd_addr == regfile_pkg::reg_pc) begin
      rd_data = pc;
    end else if (kind == regfile_pkg::rd_ones && rd_addr == regfile_pkg::reg_ones) begin
      rd_data = '1;
    end else begin
      rd_data = merged;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the register file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

top=tb_regfile_2w10r
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert \
  --top-module "$top" --Mdir "$build_dir" -o "$top" \
  -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
  echo "Simulation reported failures, see $log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== testbench/regfile_props.sv ====
`timescale 1ns/1ps

// Checks on the registers with fixed read values

module regfile_props (
  input  logic                              clka,
  input  logic                              rst,
  input  logic [regfile_pkg::xlen-1:0]      pc0,
  input  logic [regfile_pkg::xlen-1:0]      pc1,
  input  regfile_pkg::rd_addr_vec_t         rd_addr,
  input  regfile_pkg::rd_data_vec_t         rd_data
);

  // ====================
  // Per-port checks
  // ====================

  for (genvar k = 0; k < regfile_pkg::nrd; k++) begin : g_port
    localparam int lane  = k / regfile_pkg::rd_per_lane;
    localparam bit fifth = (k % regfile_pkg::rd_per_lane) == (regfile_pkg::rd_per_lane - 1);

    // Register 0 is hardwired on every port
    a_zero: assert property (@(posedge clka) disable iff (rst)
      rd_addr[k] == regfile_pkg::reg_zero |-> rd_data[k] == '0)
      else $error("Register 0 read nonzero on port %0d", k);

    if (fifth) begin : g_ones
      a_ones: assert property (@(posedge clka) disable iff (rst)
        rd_addr[k] == regfile_pkg::reg_ones |-> rd_data[k] == '1)
        else $error("Register 63 did not read all ones on port %0d", k);
    end else begin : g_pc
      // Operand ports of a lane see that lane's pc
      a_pc: assert property (@(posedge clka) disable iff (rst)
        rd_addr[k] == regfile_pkg::reg_pc |-> rd_data[k] == ((lane == 0) ? pc0 : pc1))
        else $error("Register 53 did not read the lane pc on port %0d", k);
    end
  end

endmodule

bind regfile_2w10r regfile_props regfile_props_inst (
  .clka    (clka),
  .rst     (rst),
  .pc0     (pc0),
  .pc1     (pc1),
  .rd_addr (rd_addr),
  .rd_data (rd_data)
);

// ==== testbench/tb_regfile_2w10r.sv ====
`timescale 1ns/1ps

module tb_regfile_2w10r;

  // ====================
  // Run length
  // ====================

  localparam int clk_period      = 4;
  localparam int reset_cycles    = 3;
  localparam int sweep_cycles    = 64;
  localparam int rand_cycles     = 400;
  localparam int directed_cycles = 16;
  localparam int test_cycles     = sweep_cycles + rand_cycles + directed_cycles;
  localparam int watchdog_ns     = (reset_cycles + test_cycles) * clk_period + 200;

  logic                              clka;
  logic                              rst;
  regfile_pkg::wr_port_t             wr0;
  regfile_pkg::wr_port_t             wr1;
  logic [regfile_pkg::xlen-1:0]      pc0;
  logic [regfile_pkg::xlen-1:0]      pc1;
  regfile_pkg::rd_addr_vec_t         rd_addr;
  regfile_pkg::rd_data_vec_t         rd_data;

  // Expected contents of every register after all committed writes
  logic [regfile_pkg::xlen-1:0]      shadow [regfile_pkg::nregs];
  logic [31:0]                       lfsr_state;
  int                                errors;
  int                                checks;

  regfile_2w10r regfile_2w10r_inst (
    .clka    (clka),
    .rst     (rst),
    .wr0     (wr0),
    .wr1     (wr1),
    .pc0     (pc0),
    .pc1     (pc1),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  initial begin
    clka = 1'b0;
    forever #(clk_period / 2) clka = ~clka;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("FAIL: see errors above");
    $finish;
  end

  // ====================
  // Random numbers
  // ====================

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic [regfile_pkg::reg_aw-1:0] rand_addr();
    logic [63:0] v;
    v = take_bits(regfile_pkg::reg_aw);
    return v[regfile_pkg::reg_aw-1:0];
  endfunction

  function automatic logic [regfile_pkg::nbytes-1:0] rand_be();
    logic [63:0] v;
    v = take_bits(regfile_pkg::nbytes);
    return v[regfile_pkg::nbytes-1:0];
  endfunction

  function automatic logic [1:0] rand_sel();
    logic [63:0] v;
    v = take_bits(2);
    return v[1:0];
  endfunction

  // ====================
  // Reference model
  // ====================

  // Specials first, then bypass from port 1, then port 0, then storage
  function automatic logic [63:0] expected_read(input int k,
                                                input logic [regfile_pkg::reg_aw-1:0] addr);
    logic [63:0] v;
    bit          fifth;
    v = shadow[addr];
    fifth = (k % regfile_pkg::rd_per_lane) == (regfile_pkg::rd_per_lane - 1);
    if (addr == regfile_pkg::reg_zero) begin
      return '0;
    end
    if (!fifth && addr == regfile_pkg::reg_pc) begin
      return (k < regfile_pkg::rd_per_lane) ? pc0 : pc1;
    end
    if (fifth && addr == regfile_pkg::reg_ones) begin
      return '1;
    end
    for (int b = 0; b < regfile_pkg::nbytes; b++) begin
      if (wr1.en && wr1.addr == addr && wr1.be[b]) begin
        v[b*8 +: 8] = wr1.data[b*8 +: 8];
      end else if (wr0.en && wr0.addr == addr && wr0.be[b]) begin
        v[b*8 +: 8] = wr0.data[b*8 +: 8];
      end
    end
    return v;
  endfunction

  // Port 0 bytes land first so that port 1 overrides a shared byte
  task automatic commit_writes();
    for (int b = 0; b < regfile_pkg::nbytes; b++) begin
      if (wr0.en && wr0.be[b]) begin
        shadow[wr0.addr][b*8 +: 8] = wr0.data[b*8 +: 8];
      end
    end
    for (int b = 0; b < regfile_pkg::nbytes; b++) begin
      if (wr1.en && wr1.be[b]) begin
        shadow[wr1.addr][b*8 +: 8] = wr1.data[b*8 +: 8];
      end
    end
  endtask

  task automatic check_reads();
    logic [63:0] exp;
    for (int k = 0; k < regfile_pkg::nrd; k++) begin
      exp = expected_read(k, rd_addr[k]);
      checks++;
      assert (rd_data[k] === exp) else begin
        errors++;
        $display("ERROR rd_data[%0d] addr %0d: expected %h, actual %h",
                 k, rd_addr[k], exp, rd_data[k]);
      end
    end
  endtask

  // ====================
  // Stimulus helpers
  // ====================

  function automatic regfile_pkg::wr_port_t make_write(
    input logic [regfile_pkg::nbytes-1:0] be,
    input logic [regfile_pkg::reg_aw-1:0] addr,
    input logic [regfile_pkg::xlen-1:0]   data
  );
    regfile_pkg::wr_port_t w;
    w.en   = 1'b1;
    w.be   = be;
    w.addr = addr;
    w.data = data;
    return w;
  endfunction

  task automatic read_all(input logic [regfile_pkg::reg_aw-1:0] addr);
    for (int k = 0; k < regfile_pkg::nrd; k++) begin
      rd_addr[k] = addr;
    end
  endtask

  // Reads lean towards the write addresses so bypass is hit often
  task automatic drive_random();
    logic [1:0] sel;
    sel = rand_sel();
    wr0 = make_write(rand_be(), rand_addr(), take_bits(64));
    wr0.en = |sel;
    sel = rand_sel();
    wr1 = make_write(rand_be(), rand_addr(), take_bits(64));
    wr1.en = |sel;
    sel = rand_sel();
    if (sel == 2'd0) begin
      wr1.addr = wr0.addr;
    end
    for (int k = 0; k < regfile_pkg::nrd; k++) begin
      sel = rand_sel();
      case (sel)
        2'd0:    rd_addr[k] = wr0.addr;
        2'd1:    rd_addr[k] = wr1.addr;
        default: rd_addr[k] = rand_addr();
      endcase
    end
    pc0 = take_bits(64);
    pc1 = take_bits(64);
  endtask

  // Inputs are already driven, check before the edge and commit after it
  task automatic end_cycle();
    #2;
    check_reads();
    @(posedge clka);
    commit_writes();
    #1;
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    rst        = 1'b1;
    wr0        = '0;
    wr1        = '0;
    pc0        = '0;
    pc1        = '0;
    rd_addr    = '0;
    lfsr_state = 32'h931d;
    errors     = 0;
    checks     = 0;
    for (int r = 0; r < regfile_pkg::nregs; r++) begin
      shadow[r] = '0;
    end
    repeat (reset_cycles) @(posedge clka);
    #1;
    rst = 1'b0;

    // Every register reads zero after reset, and writes to register 0 vanish
    for (int a = 0; a < regfile_pkg::nregs; a++) begin
      pc0 = take_bits(64);
      pc1 = take_bits(64);
      read_all(a[regfile_pkg::reg_aw-1:0]);
      end_cycle();
    end
    wr0 = make_write(8'hff, regfile_pkg::reg_zero, take_bits(64));
    wr1 = make_write(8'h5a, regfile_pkg::reg_zero, take_bits(64));
    read_all(regfile_pkg::reg_zero);
    end_cycle();
    wr0 = '0;
    wr1 = '0;
    end_cycle();

    // Registers 53 and 63 also get stored data, seen only on the other ports
    wr0 = make_write(8'hff, regfile_pkg::reg_pc, take_bits(64));
    wr1 = make_write(8'hff, regfile_pkg::reg_ones, take_bits(64));
    read_all(regfile_pkg::reg_pc);
    end_cycle();
    wr0 = '0;
    wr1 = '0;
    pc0 = take_bits(64);
    pc1 = take_bits(64);
    read_all(regfile_pkg::reg_ones);
    end_cycle();
    pc0 = take_bits(64);
    read_all(regfile_pkg::reg_pc);
    end_cycle();
    read_all(regfile_pkg::reg_ones);
    end_cycle();

    repeat (rand_cycles) begin
      drive_random();
      end_cycle();
    end

    // Same-cycle bypass of a partial write over stored bytes
    wr0 = make_write(8'hff, 6'd10, 64'h1111_2222_3333_4444);
    wr1 = '0;
    read_all(6'd10);
    end_cycle();
    wr0 = make_write(8'h0f, 6'd10, 64'haaaa_bbbb_cccc_dddd);
    end_cycle();
    wr0 = '0;
    end_cycle();

    // Both ports hit the same bytes and port 1 must win
    wr0 = make_write(8'hff, 6'd20, 64'h0123_4567_89ab_cdef);
    wr1 = make_write(8'h3c, 6'd20, 64'hfedc_ba98_7654_3210);
    read_all(6'd20);
    end_cycle();
    wr0 = '0;
    wr1 = '0;
    end_cycle();

    // Full write from port 0, partial from port 1, then port 0 takes back two bytes
    wr0 = make_write(8'hff, 6'd30, 64'h5555_6666_7777_8888);
    read_all(6'd30);
    end_cycle();
    wr0 = '0;
    wr1 = make_write(8'ha5, 6'd30, 64'h9999_aaaa_bbbb_cccc);
    end_cycle();
    wr1 = '0;
    wr0 = make_write(8'h81, 6'd30, 64'hdddd_eeee_ffff_0000);
    end_cycle();
    wr0 = '0;
    end_cycle();

    $display("Errors: %0d of %0d read checks failed", errors, checks);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
